/* sources.f */
+incdir+include
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/ctrlBus.sv
logic/instDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/fetchUnit.sv
logic/coreTop.sv
testbench/coreChecker.sv
testbench/coreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module coreTb -o coreSim
./obj_dir/coreSim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	echo "run.sh: testbench passed"
	exit 0
fi
echo "run.sh: testbench failed"
exit 1

/* testbench/coreTb.sv */
`include "core_defines.svh"

module coreTb import isaPkg::*; ();
	localparam int progWords = 256;
	localparam int dataBytes = 1024;
	localparam int haltLimit = 2000;
	localparam logic [31:0] nopInst = 32'h0000_0013; // addi x0, x0, 0

	logic             clk = 1'b0;
	logic             arstN;
	logic [`XLEN-1:0] inst;
	logic [`XLEN-1:0] readData;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] dataAddr;
	logic [`XLEN-1:0] storeData;
	memSizeE          dataSize;
	logic             memWrite;
	logic             halt;
	logic [31:0]      imem [progWords];
	logic [7:0]       dmem [dataBytes];
	logic [9:0]       lane;
	int               seed;
	int               errorCount;
	int               checkCount;
	int               timeouts;

	coreTop i_coreTop (
		.clk(clk), .arstN(arstN), .inst(inst), .readData(readData), .pc(pc),
		.dataAddr(dataAddr), .storeData(storeData), .dataSize(dataSize),
		.memWrite(memWrite), .halt(halt)
	);

	coreChecker refModel (
		.clk(clk), .arstN(arstN), .inst(inst), .pc(pc), .dataAddr(dataAddr),
		.storeData(storeData), .dataSize(dataSize), .memWrite(memWrite), .halt(halt),
		.errorCount(errorCount), .checkCount(checkCount)
	);

	always #10 clk = ~clk;

	assign inst     = arstN ? imem[pc[9:2]] : nopInst; // nop while in reset
	assign lane     = dataAddr[9:0];
	assign readData = {dmem[10'(lane + 3)], dmem[10'(lane + 2)], dmem[10'(lane + 1)], dmem[lane]};

	// byte lanes follow the access size
	always @(posedge clk) begin
		if (arstN && memWrite) begin
			dmem[lane] <= storeData[7:0];
			if (dataSize != sizeByte)
				dmem[10'(lane + 1)] <= storeData[15:8];
			if (dataSize == sizeWord) begin
				dmem[10'(lane + 2)] <= storeData[23:16];
				dmem[10'(lane + 3)] <= storeData[31:24];
			end
		end
	end

	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [7:0] fillByte(input int addr);
		return 8'((addr * 37) ^ (addr >> 5) ^ 8'h5a);
	endfunction

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opOp};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// forward-only control flow, so every run reaches the final ebreak
	task automatic buildProgram();
		int          idx;
		int          target;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic        alt;
		logic        hasResult;
		idx = 0;
		while (idx < progWords - 1) begin
			rd        = 5'(pick(31) + 1);
			rs1       = 5'(pick(32));
			rs2       = 5'(pick(32));
			f3        = 3'(pick(8));
			alt       = (f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1;
			target    = idx + 1 + pick(6);
			hasResult = 1'b1;
			if (target > progWords - 1)
				target = progWords - 1;
			case (pick(10))
				0, 1: imem[idx] = rType({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
				2, 3: begin
					if (f3 == 3'd1 || f3 == 3'd5)
						imm = {1'b0, alt, 5'b0, rs2}; // shamt in rs2 slot
					else
						imm = 12'(pick(4096));
					imem[idx] = iType(imm, rs1, f3, rd, opOpImm);
				end
				4: begin
					f3 = 3'(pick(5));
					if (f3 > 3'd2)
						f3 = f3 + 3'd1; // lbu, lhu
					imm = 12'(pick(dataBytes)) & ~((12'd1 << f3[1:0]) - 12'd1);
					imem[idx] = iType(imm, 5'd0, f3, rd, opLoad);
				end
				5: begin
					f3 = 3'(pick(3));
					imm = 12'(pick(dataBytes)) & ~((12'd1 << f3[1:0]) - 12'd1);
					imem[idx] = sType(imm, rs2, 5'd0, f3);
					hasResult = 1'b0;
				end
				6: begin
					f3 = 3'(pick(6));
					if (f3 > 3'd1)
						f3 = f3 + 3'd2;
					imem[idx] = bType(13'((target - idx) * 4), rs2, rs1, f3);
					hasResult = 1'b0;
				end
				7: begin
					imem[idx] = jType(21'((target - idx) * 4), rd);
					hasResult = (target == idx + 1); // link seen when the store is the target
				end
				8: begin
					imem[idx] = iType(12'(target * 4), 5'd0, 3'd0, rd, opJalr);
					hasResult = (target == idx + 1);
				end
				default: imem[idx] = uType(20'(pick(1 << 20)), rd, pick(2) == 1 ? opLui : opAuipc);
			endcase
			idx++;
			if (hasResult && idx < progWords - 1) begin
				imem[idx] = sType(12'(pick(dataBytes / 4) * 4), rd, 5'd0, 3'd2); // expose rd
				idx++;
			end
		end
		imem[progWords - 1] = ebreakInst;
	endtask

	task automatic waitForHalt(input string what);
		int cycles;
		cycles = 0;
		while (!halt && cycles < haltLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halt) begin
			timeouts++;
			$display("timeout: core did not halt during %s within %0d cycles", what, haltLimit);
		end
	endtask

	initial begin
		arstN    = 1'b0;
		seed     = 32'h1bcb;
		timeouts = 0;
		for (int i = 0; i < dataBytes; i++) begin
			dmem[i] = fillByte(i);
		end
		buildProgram();
		repeat (2) @(posedge clk);
		#1 arstN = 1'b1;
		waitForHalt("first run");
		if (timeouts == 0) begin
			repeat (20) @(posedge clk); // pc has to hold here
			#1 arstN = 1'b0;
			repeat (2) @(posedge clk);
			#1 arstN = 1'b1;
			waitForHalt("run after second reset");
		end
		repeat (2) @(posedge clk);
		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeouts);
		if (errorCount == 0 && timeouts == 0 && checkCount > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end
endmodule

/* testbench/coreChecker.sv */
`include "core_defines.svh"

module coreChecker import isaPkg::*; (
	input  logic             clk,
	input  logic             arstN,
	input  logic [`XLEN-1:0] inst,
	input  logic [`XLEN-1:0] pc,
	input  logic [`XLEN-1:0] dataAddr,
	input  logic [`XLEN-1:0] storeData,
	input  memSizeE          dataSize,
	input  logic             memWrite,
	input  logic             halt,
	output int               errorCount,
	output int               checkCount
);
	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic [7:0]       mem [1024];
	logic [`XLEN-1:0] modelPc;
	logic             modelHalted;
	int               errors = 0;
	int               checks = 0;

	assign errorCount = errors;
	assign checkCount = checks;

	// same power-up image as the testbench data memory
	function automatic logic [7:0] fillByte(input int addr);
		return 8'((addr * 37) ^ (addr >> 5) ^ 8'h5a);
	endfunction

	function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
			input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: begin
				if (alt)
					return $unsigned($signed(x) >>> y[4:0]);
				return x >> y[4:0];
			end
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic taken(input logic [2:0] f3, input logic [31:0] x,
			input logic [31:0] y);
		case (f3)
			3'd0: return x == y;
			3'd1: return x != y;
			3'd4: return $signed(x) < $signed(y);
			3'd5: return $signed(x) >= $signed(y);
			3'd6: return x < y;
			default: return x >= y;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h at time %0t", name, exp, act, $time);
		end
	endtask

	// one instruction of the reference model, checked before it retires
	task automatic execute();
		logic [6:0]  opcode;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [31:0] a, b, immI, immS, immB, immU, immJ;
		logic [31:0] res, nextPc, addr, word;
		logic        wr, stopNow;
		opcode  = inst[6:0];
		f3      = inst[14:12];
		rd      = inst[11:7];
		a       = regs[inst[19:15]];
		b       = regs[inst[24:20]];
		immI    = {{20{inst[31]}}, inst[31:20]};
		immS    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		immB    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		immU    = {inst[31:12], 12'b0};
		immJ    = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		nextPc  = modelPc + 32'd4;
		res     = '0;
		wr      = 1'b1;
		stopNow = modelHalted || inst == ebreakInst;
		compare("pc", modelPc, pc);
		compare("halt", 32'(stopNow), 32'(halt));
		compare("memWrite", 32'(opcode == opStore && !stopNow), 32'(memWrite));
		if (stopNow) begin
			modelHalted = 1'b1; // pc frozen until reset
			return;
		end
		case (opcode)
			opOp:    res = arith(f3, inst[30], a, b);
			opOpImm: res = arith(f3, f3 == 3'd5 && inst[30], a, immI);
			opLui:   res = immU;
			opAuipc: res = modelPc + immU;
			opJal: begin
				res    = modelPc + 32'd4;
				nextPc = modelPc + immJ;
			end
			opJalr: begin
				res    = modelPc + 32'd4;
				nextPc = (a + immI) & ~32'd1;
			end
			opBranch: begin
				wr = 1'b0;
				if (taken(f3, a, b))
					nextPc = modelPc + immB;
			end
			opLoad: begin
				addr = a + immI;
				compare("load dataAddr", addr, dataAddr);
				compare("load dataSize", 32'(f3[1:0]), 32'(dataSize));
				word = {mem[10'(addr + 3)], mem[10'(addr + 2)], mem[10'(addr + 1)], mem[addr[9:0]]};
				case (f3)
					3'd0: res = {{24{word[7]}}, word[7:0]};
					3'd1: res = {{16{word[15]}}, word[15:0]};
					3'd4: res = {24'b0, word[7:0]};
					3'd5: res = {16'b0, word[15:0]};
					default: res = word;
				endcase
			end
			opStore: begin
				wr   = 1'b0;
				addr = a + immS;
				compare("store dataAddr", addr, dataAddr);
				compare("store dataSize", 32'(f3[1:0]), 32'(dataSize));
				compare("store data", b, storeData);
				mem[addr[9:0]] = b[7:0];
				if (f3[1:0] != 2'd0)
					mem[10'(addr + 1)] = b[15:8];
				if (f3[1:0] == 2'd2) begin
					mem[10'(addr + 2)] = b[23:16];
					mem[10'(addr + 3)] = b[31:24];
				end
			end
			default: wr = 1'b0; // other SYSTEM words act as nop
		endcase
		if (wr && rd != 5'd0)
			regs[rd] = res;
		modelPc = nextPc;
	endtask

	initial begin
		for (int i = 0; i < 1024; i++) begin
			mem[i] = fillByte(i);
		end
	end

	always @(negedge clk) begin
		if (!arstN) begin
			modelPc     = `RESET_VECTOR;
			modelHalted = 1'b0;
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] = '0;
			end
			compare("reset pc", `RESET_VECTOR, pc);
			compare("reset memWrite", 32'd0, 32'(memWrite));
			compare("reset halt", 32'd0, 32'(halt));
		end else begin
			execute();
		end
	end
endmodule

/* logic/coreTop.sv */
`include "core_defines.svh"

module coreTop import isaPkg::*; import ctrlPkg::*; (
	input  logic             clk,
	input  logic             arstN,
	input  logic [`XLEN-1:0] inst,
	input  logic [`XLEN-1:0] readData,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] dataAddr,
	output logic [`XLEN-1:0] storeData,
	output memSizeE          dataSize,
	output logic             memWrite,
	output logic             halt
);
	instFieldsT       f;
	logic [`XLEN-1:0] rs1Data, rs2Data;
	logic [`XLEN-1:0] opA, opB;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] loadExt;
	logic [`XLEN-1:0] writeData;
	logic [`XLEN-1:0] pcPlus4, pcImm;
	logic             branchTaken;
	logic             halted;

	ctrlBus cBus ();

	assign f = inst;

	instDecoder uDecoder (.inst(inst), .ctrl(cBus));

	regFile uRegFile (
		.clk(clk), .arstN(arstN), .writeEn(cBus.regWrite & ~halted),
		.rs1Addr(f.rs1), .rs2Addr(f.rs2), .rdAddr(f.rd),
		.writeData(writeData), .rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	assign opA = (cBus.srcASel == srcPc) ? pc : rs1Data;
	assign opB = cBus.useImm ? cBus.imm : rs2Data;

	alu uAlu (
		.opA(opA), .opB(opB), .aluOp(cBus.aluOp), .branchFunct(cBus.branchFunct),
		.result(aluResult), .branchTaken(branchTaken)
	);

	fetchUnit uFetch (
		.clk(clk), .arstN(arstN), .branchTaken(branchTaken), .ctrl(cBus),
		.jalrTarget(aluResult), .pc(pc), .pcPlus4(pcPlus4), .pcImm(pcImm), .halted(halted)
	);

	// readData already sits in the low lanes
	always_comb begin
		case (cBus.memSize)
			sizeByte: loadExt = {{(`XLEN-8){~cBus.loadUnsigned & readData[7]}}, readData[7:0]};
			sizeHalf: loadExt = {{(`XLEN-16){~cBus.loadUnsigned & readData[15]}},
				readData[15:0]};
			default:  loadExt = readData;
		endcase
	end

	always_comb begin
		case (cBus.wbSel)
			wbMem:     writeData = loadExt;
			wbPcPlus4: writeData = pcPlus4; // link
			wbPcImm:   writeData = pcImm;
			default:   writeData = aluResult;
		endcase
	end

	assign dataAddr  = aluResult;
	assign storeData = rs2Data;
	assign dataSize  = cBus.memSize;
	assign memWrite  = cBus.memWrite & ~halted;
	assign halt      = halted;
endmodule

/* logic/fetchUnit.sv */
`include "core_defines.svh"

module fetchUnit (
	input  logic             clk,
	input  logic             arstN,
	input  logic             branchTaken,
	ctrlBus.datapath         ctrl,
	input  logic [`XLEN-1:0] jalrTarget,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] pcPlus4,
	output logic [`XLEN-1:0] pcImm,
	output logic             halted
);
	logic             haltQ; // sticky ebreak
	logic [`XLEN-1:0] nextPc;

	assign pcPlus4 = pc + `XLEN'd4;
	assign pcImm   = pc + ctrl.imm;
	assign halted  = haltQ | ctrl.halt; // also high on the ebreak itself

	always_comb begin
		if (halted)
			nextPc = pc;
		else if (ctrl.isJalr)
			nextPc = {jalrTarget[`XLEN-1:1], 1'b0};
		else if (ctrl.isJal || (ctrl.isBranch && branchTaken))
			nextPc = pcImm;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc    <= `RESET_VECTOR;
			haltQ <= 1'b0;
		end else begin
			pc    <= nextPc;
			haltQ <= halted;
		end
	end

	assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
		else $error("pc lost word alignment");
endmodule

/* logic/alu.sv */
`include "core_defines.svh"

module alu import isaPkg::*; import ctrlPkg::*; (
	input  logic [`XLEN-1:0] opA,
	input  logic [`XLEN-1:0] opB,
	input  aluOpE            aluOp,
	input  branchFunctE      branchFunct,
	output logic [`XLEN-1:0] result,
	output logic             branchTaken
);
	logic [4:0] shamt;
	logic       isEq;
	logic       isLt;
	logic       isLtu;

	assign shamt = opB[4:0];

	always_comb begin
		case (aluOp)
			aluAdd:   result = opA + opB;
			aluSub:   result = opA - opB;
			aluAnd:   result = opA & opB;
			aluOr:    result = opA | opB;
			aluXor:   result = opA ^ opB;
			aluSlt:   result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			aluSltu:  result = {{(`XLEN-1){1'b0}}, opA < opB};
			aluSll:   result = opA << shamt;
			aluSrl:   result = opA >> shamt;
			aluSra:   result = $unsigned($signed(opA) >>> shamt);
			aluPassB: result = opB;
			default:  result = opA + opB;
		endcase
	end

	// compare path independent of aluOp
	assign isEq  = (opA == opB);
	assign isLt  = ($signed(opA) < $signed(opB));
	assign isLtu = (opA < opB);

	always_comb begin
		case (branchFunct)
			beq:     branchTaken = isEq;
			bne:     branchTaken = !isEq;
			blt:     branchTaken = isLt;
			bge:     branchTaken = !isLt;
			bltu:    branchTaken = isLtu;
			bgeu:    branchTaken = !isLtu;
			default: branchTaken = 1'b0;
		endcase
	end
endmodule

/* logic/regFile.sv */
`include "core_defines.svh"

module regFile (
	input  logic             clk,
	input  logic             arstN,
	input  logic             writeEn,
	input  logic [4:0]       rs1Addr,
	input  logic [4:0]       rs2Addr,
	input  logic [4:0]       rdAddr,
	input  logic [`XLEN-1:0] writeData,
	output logic [`XLEN-1:0] rs1Data,
	output logic [`XLEN-1:0] rs2Data
);
	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && rdAddr != 5'd0) begin // x0 stays zero
			regs[rdAddr] <= writeData;
		end
	end

	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

	// x0 must never pick up a value from any earlier write
	assert property (@(posedge clk) disable iff (!arstN)
		(rs1Addr == 5'd0) |-> (rs1Data == '0))
		else $error("x0 read back nonzero on rs1");

	assert property (@(posedge clk) disable iff (!arstN)
		(rs2Addr == 5'd0) |-> (rs2Data == '0))
		else $error("x0 read back nonzero on rs2");
endmodule

/* logic/instDecoder.sv */
`include "core_defines.svh"

module instDecoder import isaPkg::*; import ctrlPkg::*; (
	input logic [`XLEN-1:0] inst,
	ctrlBus.decoder         ctrl
);
	instFieldsT       f;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immU;
	logic [`XLEN-1:0] immJ;

	assign f = inst;

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// alt selects sub / sra
	function automatic aluOpE aluFromFunct(input logic [2:0] funct3, input logic alt);
		aluOpE op;
		case (funct3)
			3'd0: op = alt ? aluSub : aluAdd;
			3'd1: op = aluSll;
			3'd2: op = aluSlt;
			3'd3: op = aluSltu;
			3'd4: op = aluXor;
			3'd5: op = alt ? aluSra : aluSrl;
			3'd6: op = aluOr;
			default: op = aluAnd;
		endcase
		return op;
	endfunction

	always_comb begin
		// nop unless the opcode says otherwise
		ctrl.aluOp        = aluAdd;
		ctrl.srcASel      = srcReg;
		ctrl.useImm       = 1'b0;
		ctrl.imm          = immI;
		ctrl.wbSel        = wbAlu;
		ctrl.regWrite     = 1'b0;
		ctrl.memWrite     = 1'b0;
		ctrl.memSize      = sizeWord;
		ctrl.loadUnsigned = 1'b0;
		ctrl.isBranch     = 1'b0;
		ctrl.branchFunct  = branchFunctE'(f.funct3);
		ctrl.isJal        = 1'b0;
		ctrl.isJalr       = 1'b0;
		ctrl.halt         = 1'b0;

		case (f.opcode)
			opOp: begin
				ctrl.aluOp    = aluFromFunct(f.funct3, f.funct7[5]);
				ctrl.regWrite = 1'b1;
			end
			opOpImm: begin
				ctrl.aluOp    = aluFromFunct(f.funct3, f.funct3 == 3'd5 && f.funct7[5]);
				ctrl.useImm   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opLoad: begin
				ctrl.useImm       = 1'b1;
				ctrl.wbSel        = wbMem;
				ctrl.regWrite     = 1'b1;
				ctrl.memSize      = memSizeE'(f.funct3[1:0]);
				ctrl.loadUnsigned = f.funct3[2];
			end
			opStore: begin
				ctrl.useImm   = 1'b1;
				ctrl.imm      = immS;
				ctrl.memWrite = 1'b1;
				ctrl.memSize  = memSizeE'(f.funct3[1:0]);
			end
			opBranch: begin
				ctrl.aluOp    = aluSub; // rs1 vs rs2
				ctrl.imm      = immB;
				ctrl.isBranch = 1'b1;
			end
			opJal: begin
				ctrl.srcASel  = srcPc; // ALU shows the target too
				ctrl.useImm   = 1'b1;
				ctrl.imm      = immJ;
				ctrl.wbSel    = wbPcPlus4;
				ctrl.regWrite = 1'b1;
				ctrl.isJal    = 1'b1;
			end
			opJalr: begin
				ctrl.useImm   = 1'b1;
				ctrl.wbSel    = wbPcPlus4;
				ctrl.regWrite = 1'b1;
				ctrl.isJalr   = 1'b1;
			end
			opLui: begin
				ctrl.aluOp    = aluPassB;
				ctrl.useImm   = 1'b1;
				ctrl.imm      = immU;
				ctrl.regWrite = 1'b1;
			end
			opAuipc: begin
				ctrl.imm      = immU;
				ctrl.wbSel    = wbPcImm;
				ctrl.regWrite = 1'b1;
			end
			opSystem: ctrl.halt = (inst == ebreakInst); // rest of SYSTEM is a nop
			default: ;
		endcase
	end

	always_comb begin
		assert final (!(ctrl.memWrite && ctrl.regWrite))
			else $error("decoder drives memWrite and regWrite together");
	end
endmodule

/* logic/ctrlBus.sv */
`include "core_defines.svh"

interface ctrlBus import isaPkg::*, ctrlPkg::*; ();
	aluOpE               aluOp;
	srcASelE             srcASel;
	logic                useImm;
	logic [`XLEN-1:0]    imm;
	wbSelE               wbSel;
	logic                regWrite;
	logic                memWrite;
	memSizeE             memSize;
	logic                loadUnsigned;
	logic                isBranch;
	branchFunctE         branchFunct;
	logic                isJal;
	logic                isJalr;
	logic                halt; // ebreak seen

	modport decoder (
		output aluOp, srcASel, useImm, imm, wbSel, regWrite, memWrite, memSize,
			loadUnsigned, isBranch, branchFunct, isJal, isJalr, halt
	);

	modport datapath (
		input aluOp, srcASel, useImm, imm, wbSel, regWrite, memWrite, memSize,
			loadUnsigned, isBranch, branchFunct, isJal, isJalr, halt
	);
endinterface

/* logic/ctrlPkg.sv */
package ctrlPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluPassB // lui
	} aluOpE;

	// register writeback source
	typedef enum logic [1:0] {
		wbAlu     = 2'd0,
		wbMem     = 2'd1,
		wbPcPlus4 = 2'd2,
		wbPcImm   = 2'd3
	} wbSelE;

	// first ALU operand
	typedef enum logic {
		srcReg = 1'b0,
		srcPc  = 1'b1
	} srcASelE;

endpackage

/* logic/isaPkg.sv */
package isaPkg;

	// major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opOpImm  = 7'b0010011,
		opOp     = 7'b0110011,
		opSystem = 7'b1110011
	} opcodeE;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branchFunctE;

	// funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		sizeByte = 2'd0,
		sizeHalf = 2'd1,
		sizeWord = 2'd2
	} memSizeE;

	// R-type field layout, other formats reuse the same positions
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instFieldsT;

	localparam logic [31:0] ebreakInst = 32'h0010_0073;

endpackage

/* include/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// first fetch address after reset
`define RESET_VECTOR 32'h0000_0000

`endif
